// File: gt_bus_pkg.sv
package gt_bus_pkg;

    // widths of the gtp_ wishbone target port
    localparam int WB_ADR_W = 14;
    localparam int WB_DAT_W = 32;
    localparam int WB_SEL_W = 4;

    typedef logic [WB_ADR_W-1:0] wb_adr_t;
    typedef logic [WB_DAT_W-1:0] wb_dat_t;
    typedef logic [WB_SEL_W-1:0] wb_sel_t;

    // lane 0 sits at byte offset 0, lane 1 at byte offset 4
    localparam int LANE_ADR_BIT = 2;

    // one accepted bus access, as seen by the control and status sides
    typedef struct packed {
        // single-cycle strobe
        logic    valid;
        logic    write;
        logic    lane;
        wb_sel_t sel;
        wb_dat_t data;
    } bus_req_t;

endpackage

// File: gt_lane_pkg.sv
package gt_lane_pkg;

    // two SFP lanes share one QPLL
    localparam int NUM_LANE = 2;

    localparam int LOOPBACK_W = 3;
    localparam int MONITOR_W  = 16;

    typedef logic [LOOPBACK_W-1:0] loopback_t;
    typedef logic [MONITOR_W-1:0]  monitor_t;

    // status word layout, identical for both lanes
    localparam int ST_RST        = 0;
    localparam int ST_PLL_LOCK   = 1;
    localparam int ST_BLOCK_LOCK = 2;
    localparam int ST_HIGH_BER   = 3;
    localparam int ST_EYE_RST    = 4;
    localparam int ST_LOOPBACK   = 8;
    localparam int ST_MONITOR    = 16;

    // control word layout
    // reset and eye reset live in byte 0, loopback in byte 1
    localparam int CT_RST      = 0;
    localparam int CT_EYE_RST  = 4;
    localparam int CT_LOOPBACK = 8;

    // per-lane status coming back from the transceiver
    typedef struct packed {
        logic     block_lock;
        logic     high_ber;
        monitor_t monitor;
    } lane_stat_t;

    // per-lane control going out to the transceiver
    typedef struct packed {
        logic      eye_rst;
        loopback_t loopback;
    } lane_ctrl_t;

endpackage

// File: gt_bus_decode.sv
module gt_bus_decode (
    input  logic                  wb_clk_i,
    input  logic                  rst_i,
    input  logic                  cyc_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    input  gt_bus_pkg::wb_adr_t   adr_i,
    input  gt_bus_pkg::wb_sel_t   sel_i,
    input  gt_bus_pkg::wb_dat_t   dat_i,
    output gt_bus_pkg::bus_req_t  req_o
);

    typedef enum logic {
        IDLE,
        WAIT_END
    } state_t;

    state_t state_q;
    gt_bus_pkg::bus_req_t req_q;

    logic access;

    // only a fresh strobe seen from idle starts an access
    assign access = (state_q == IDLE) && cyc_i && stb_i;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            state_q     <= IDLE;
            req_q.valid <= 1'b0;
        end else begin
            req_q.valid <= access;
            case (state_q)
                IDLE: begin
                    if (access) begin
                        state_q <= WAIT_END;
                    end
                end
                WAIT_END: begin
                    // hold here until the host lets go of the strobe
                    if (!stb_i || !cyc_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // request payload, loaded alongside the valid strobe
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            req_q.write <= we_i;
            req_q.lane  <= adr_i[gt_bus_pkg::LANE_ADR_BIT];
            req_q.sel   <= sel_i;
            req_q.data  <= dat_i;
        end
    end

    assign req_o = req_q;

endmodule

// File: gt_lane_ctrl.sv
module gt_lane_ctrl (
    input  logic                    wb_clk_i,
    input  logic                    rst_i,
    input  gt_bus_pkg::bus_req_t    req_i,
    output logic                    xcvr_rst_o,
    output gt_lane_pkg::lane_ctrl_t lane_ctrl_o [gt_lane_pkg::NUM_LANE]
);

    logic                    xcvr_rst_q;
    gt_lane_pkg::lane_ctrl_t lane_ctrl_q [gt_lane_pkg::NUM_LANE];

    logic wr_byte0;
    logic wr_byte1;

    // byte lanes of the control word that this write touches
    assign wr_byte0 = req_i.valid && req_i.write && req_i.sel[0];
    assign wr_byte1 = req_i.valid && req_i.write && req_i.sel[1];

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            xcvr_rst_q <= 1'b0;
            for (int i = 0; i < gt_lane_pkg::NUM_LANE; i++) begin
                lane_ctrl_q[i].eye_rst  <= 1'b0;
                lane_ctrl_q[i].loopback <= '0;
            end
        end else begin
            if (wr_byte0) begin
                // shared by both transceivers, so either lane address sets it
                xcvr_rst_q <= req_i.data[gt_lane_pkg::CT_RST];
                lane_ctrl_q[req_i.lane].eye_rst <= req_i.data[gt_lane_pkg::CT_EYE_RST];
            end
            if (wr_byte1) begin
                lane_ctrl_q[req_i.lane].loopback <=
                    req_i.data[gt_lane_pkg::CT_LOOPBACK +: gt_lane_pkg::LOOPBACK_W];
            end
        end
    end

    assign xcvr_rst_o  = xcvr_rst_q;
    assign lane_ctrl_o = lane_ctrl_q;

endmodule

// File: gt_status_read.sv
module gt_status_read (
    input  logic                    wb_clk_i,
    input  logic                    rst_i,
    input  gt_bus_pkg::bus_req_t    req_i,
    input  logic                    xcvr_rst_i,
    input  gt_lane_pkg::lane_ctrl_t lane_ctrl_i [gt_lane_pkg::NUM_LANE],
    input  logic                    qpll_lock_i,
    input  gt_lane_pkg::lane_stat_t lane_stat_i [gt_lane_pkg::NUM_LANE],
    output gt_bus_pkg::wb_dat_t     dat_o,
    output logic                    ack_o
);

    gt_bus_pkg::wb_dat_t stat_word [gt_lane_pkg::NUM_LANE];
    gt_bus_pkg::wb_dat_t rd_data_q;
    logic                ack_q;

    // live status word for each lane, unused bits stay zero
    always_comb begin
        for (int i = 0; i < gt_lane_pkg::NUM_LANE; i++) begin
            stat_word[i] = '0;
            stat_word[i][gt_lane_pkg::ST_RST]        = xcvr_rst_i;
            stat_word[i][gt_lane_pkg::ST_PLL_LOCK]   = qpll_lock_i;
            stat_word[i][gt_lane_pkg::ST_BLOCK_LOCK] = lane_stat_i[i].block_lock;
            stat_word[i][gt_lane_pkg::ST_HIGH_BER]   = lane_stat_i[i].high_ber;
            stat_word[i][gt_lane_pkg::ST_EYE_RST]    = lane_ctrl_i[i].eye_rst;
            stat_word[i][gt_lane_pkg::ST_LOOPBACK +: gt_lane_pkg::LOOPBACK_W] =
                lane_ctrl_i[i].loopback;
            stat_word[i][gt_lane_pkg::ST_MONITOR +: gt_lane_pkg::MONITOR_W] =
                lane_stat_i[i].monitor;
        end
    end

    // snapshot of the addressed lane
    // writes load zero so their ack never carries status
    always_ff @(posedge wb_clk_i) begin
        if (req_i.valid) begin
            if (req_i.write) begin
                rd_data_q <= '0;
            end else begin
                rd_data_q <= stat_word[req_i.lane];
            end
        end
    end

    // one ack per accepted request, reads and writes alike
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_i.valid;
        end
    end

    assign ack_o = ack_q;

    // data bus idles at zero outside the ack cycle
    assign dat_o = ack_q ? rd_data_q : '0;

endmodule

// File: gt_ctrl_top.sv
module gt_ctrl_top (
    input  logic                    wb_clk_i,
    input  logic                    rst_i,
    // gtp_ wishbone target
    input  logic                    cyc_i,
    input  logic                    stb_i,
    input  logic                    we_i,
    input  gt_bus_pkg::wb_adr_t     adr_i,
    input  gt_bus_pkg::wb_sel_t     sel_i,
    input  gt_bus_pkg::wb_dat_t     dat_i,
    output gt_bus_pkg::wb_dat_t     dat_o,
    output logic                    ack_o,
    // transceiver status
    input  logic                    qpll_lock_i,
    input  gt_lane_pkg::lane_stat_t lane_stat_i [gt_lane_pkg::NUM_LANE],
    // transceiver control
    output logic                    xcvr_rst_o,
    output gt_lane_pkg::lane_ctrl_t lane_ctrl_o [gt_lane_pkg::NUM_LANE]
);

    gt_bus_pkg::bus_req_t req;

    gt_bus_decode u_decode (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .cyc_i    (cyc_i),
        .stb_i    (stb_i),
        .we_i     (we_i),
        .adr_i    (adr_i),
        .sel_i    (sel_i),
        .dat_i    (dat_i),
        .req_o    (req)
    );

    gt_lane_ctrl u_ctrl (
        .wb_clk_i    (wb_clk_i),
        .rst_i       (rst_i),
        .req_i       (req),
        .xcvr_rst_o  (xcvr_rst_o),
        .lane_ctrl_o (lane_ctrl_o)
    );

    // status side reads the control registers back from the output ports
    gt_status_read u_status (
        .wb_clk_i    (wb_clk_i),
        .rst_i       (rst_i),
        .req_i       (req),
        .xcvr_rst_i  (xcvr_rst_o),
        .lane_ctrl_i (lane_ctrl_o),
        .qpll_lock_i (qpll_lock_i),
        .lane_stat_i (lane_stat_i),
        .dat_o       (dat_o),
        .ack_o       (ack_o)
    );

endmodule

// File: tb_clkgen.sv
module tb_clkgen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // reset held for the first three rising edges
    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// File: tb_checker.sv
module tb_checker (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    stb_i,
    input  logic                    we_i,
    input  logic                    ack_i,
    input  gt_bus_pkg::wb_dat_t     dat_i,
    input  logic                    xcvr_rst_i,
    input  gt_lane_pkg::lane_ctrl_t lane_ctrl_i [gt_lane_pkg::NUM_LANE],
    input  gt_bus_pkg::wb_dat_t     exp_dat_i,
    input  logic                    exp_xcvr_rst_i,
    input  gt_lane_pkg::lane_ctrl_t exp_lane_ctrl_i [gt_lane_pkg::NUM_LANE],
    output int                      acc_cnt_o,
    output int                      err_cnt_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic stb_q;
    logic ack_q;
    logic pending;
    int   wait_cnt;
    int   bad;

    always @(posedge clk_i) begin
        if (rst_i) begin
            stb_q     <= 1'b0;
            ack_q     <= 1'b0;
            pending   <= 1'b0;
            wait_cnt  <= 0;
            acc_cnt_o <= 0;
            err_cnt_o <= 0;
        end else begin
            stb_q <= stb_i;
            ack_q <= ack_i;
            // count edges from the one that accepts the strobe
            if (stb_i && !stb_q) begin
                pending  <= 1'b1;
                wait_cnt <= 1;
            end else if (pending) begin
                wait_cnt <= wait_cnt + 1;
            end
            if (ack_i && ack_q) begin
                $display("ack_o stayed high for more than one cycle at %0t", $time);
                err_cnt_o <= err_cnt_o + 1;
            end else if (ack_i && !pending) begin
                $display("ack_o rose with no access pending at %0t", $time);
                err_cnt_o <= err_cnt_o + 1;
            end else if (ack_i) begin
                bad = 0;
                if (wait_cnt != 2) begin
                    $display("MISMATCH at %0t: ack after %0d cycles, expected 2", $time, wait_cnt);
                    bad = bad + 1;
                end
                if (dat_i != exp_dat_i) begin
                    $display("MISMATCH at %0t: dat_o is %h, expected %h", $time, dat_i, exp_dat_i);
                    bad = bad + 1;
                end
                if (xcvr_rst_i != exp_xcvr_rst_i) begin
                    $display("MISMATCH at %0t: xcvr_rst_o is %b, expected %b", $time,
                             xcvr_rst_i, exp_xcvr_rst_i);
                    bad = bad + 1;
                end
                for (int i = 0; i < gt_lane_pkg::NUM_LANE; i++) begin
                    if (lane_ctrl_i[i] != exp_lane_ctrl_i[i]) begin
                        $display("MISMATCH at %0t: lane %0d control is %h, expected %h", $time,
                                 i, lane_ctrl_i[i], exp_lane_ctrl_i[i]);
                        bad = bad + 1;
                    end
                end
                $display("access %0d %s: %s", acc_cnt_o + 1, we_i ? "write" : "read",
                         bad == 0 ? "ok" : "failed");
                pending   <= 1'b0;
                acc_cnt_o <= acc_cnt_o + 1;
                err_cnt_o <= err_cnt_o + bad;
            end else if (dat_i != '0) begin
                $display("MISMATCH at %0t: dat_o is %h outside the ack", $time, dat_i);
                err_cnt_o <= err_cnt_o + 1;
            end
        end
    end

endmodule

// File: tb_top.sv
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    // words per access line in the data file
    localparam int WORDS   = 11;
    localparam int MAX_ACC = 64;

    logic                    clk;
    logic                    rst;
    logic                    cyc;
    logic                    stb;
    logic                    we;
    gt_bus_pkg::wb_adr_t     adr;
    gt_bus_pkg::wb_sel_t     sel;
    gt_bus_pkg::wb_dat_t     dat_w;
    gt_bus_pkg::wb_dat_t     dat_r;
    logic                    ack;
    logic                    qpll_lock;
    gt_lane_pkg::lane_stat_t lane_stat [gt_lane_pkg::NUM_LANE];
    logic                    xcvr_rst;
    gt_lane_pkg::lane_ctrl_t lane_ctrl [gt_lane_pkg::NUM_LANE];

    gt_bus_pkg::wb_dat_t     exp_dat;
    logic                    exp_xcvr_rst;
    gt_lane_pkg::lane_ctrl_t exp_lane_ctrl [gt_lane_pkg::NUM_LANE];

    logic [31:0] mem [MAX_ACC*WORDS];
    int          n_acc;
    bit          loaded;
    int          acc_cnt;
    int          err_cnt;

    tb_clkgen u_clkgen (
        .clk_o (clk),
        .rst_o (rst)
    );

    gt_ctrl_top UUT (
        .wb_clk_i    (clk),
        .rst_i       (rst),
        .cyc_i       (cyc),
        .stb_i       (stb),
        .we_i        (we),
        .adr_i       (adr),
        .sel_i       (sel),
        .dat_i       (dat_w),
        .dat_o       (dat_r),
        .ack_o       (ack),
        .qpll_lock_i (qpll_lock),
        .lane_stat_i (lane_stat),
        .xcvr_rst_o  (xcvr_rst),
        .lane_ctrl_o (lane_ctrl)
    );

    tb_checker u_check (
        .clk_i           (clk),
        .rst_i           (rst),
        .stb_i           (stb),
        .we_i            (we),
        .ack_i           (ack),
        .dat_i           (dat_r),
        .xcvr_rst_i      (xcvr_rst),
        .lane_ctrl_i     (lane_ctrl),
        .exp_dat_i       (exp_dat),
        .exp_xcvr_rst_i  (exp_xcvr_rst),
        .exp_lane_ctrl_i (exp_lane_ctrl),
        .acc_cnt_o       (acc_cnt),
        .err_cnt_o       (err_cnt)
    );

    // one bus access taken from line idx of the data file
    task automatic run_access(input int idx);
        int                  b;
        gt_bus_pkg::wb_adr_t a;
        b = idx * WORDS;
        a = '0;
        a[gt_bus_pkg::LANE_ADR_BIT] = mem[b+1][0];
        @(posedge clk);
        cyc              <= 1'b1;
        stb              <= 1'b1;
        we               <= mem[b][0];
        adr              <= a;
        sel              <= mem[b+2][gt_bus_pkg::WB_SEL_W-1:0];
        dat_w            <= mem[b+3];
        qpll_lock        <= mem[b+4][0];
        lane_stat[0]     <= mem[b+5][17:0];
        lane_stat[1]     <= mem[b+6][17:0];
        exp_dat          <= mem[b+7];
        exp_xcvr_rst     <= mem[b+8][0];
        exp_lane_ctrl[0] <= mem[b+9][3:0];
        exp_lane_ctrl[1] <= mem[b+10][3:0];
        do @(negedge clk); while (!ack);
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
    endtask

    initial begin
        cyc              = 1'b0;
        stb              = 1'b0;
        we               = 1'b0;
        adr              = '0;
        sel              = '0;
        dat_w            = '0;
        qpll_lock        = 1'b0;
        lane_stat[0]     = '0;
        lane_stat[1]     = '0;
        exp_dat          = '0;
        exp_xcvr_rst     = 1'b0;
        exp_lane_ctrl[0] = '0;
        exp_lane_ctrl[1] = '0;
        $readmemh("tb_input.txt", mem);
        // a line with 2 in the first column ends the list
        n_acc = 0;
        while (n_acc < MAX_ACC && mem[n_acc*WORDS] != 32'h2) begin
            n_acc = n_acc + 1;
        end
        loaded = 1'b1;
        wait (!rst);
        for (int i = 0; i < n_acc; i++) begin
            run_access(i);
        end
        repeat (3) @(posedge clk);
        if (n_acc == 0) begin
            $display("no accesses were found in tb_input.txt");
        end
        if (acc_cnt != n_acc) begin
            $display("only %0d of %0d accesses were checked", acc_cnt, n_acc);
        end
        $display("summary: %0d accesses, %0d checked, %0d errors", n_acc, acc_cnt, err_cnt);
        if (n_acc > 0 && acc_cnt == n_acc && err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog sized from the number of accesses
    initial begin
        wait (loaded);
        repeat (n_acc * 20 + 100) @(posedge clk);
        $display("timeout: the DUT stopped acknowledging after %0d accesses", acc_cnt);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: tb_input.txt
// we lane sel data qpll stat0 stat1 exp_dat exp_xcvr_rst exp_ctrl0 exp_ctrl1
// stat is {block_lock, high_ber, monitor}, ctrl is {eye_rst, loopback}, we=2 ends
0 0 F 00000000 1 2ABCD 11234 ABCD0006 0 0 0
0 1 F 00000000 1 2ABCD 11234 1234000A 0 0 0
0 0 F 00000000 0 3FFFF 11234 FFFF000C 0 0 0
1 1 3 00000510 1 2ABCD 11234 00000000 0 0 D
0 1 F 00000000 1 2ABCD 11234 1234051A 0 0 D
0 0 F 00000000 1 2ABCD 11234 ABCD0006 0 0 D
1 1 1 00000700 1 2ABCD 11234 00000000 0 0 5
0 1 F 00000000 1 2ABCD 11234 1234050A 0 0 5
1 1 2 00000311 1 2ABCD 11234 00000000 0 0 3
0 1 F 00000000 1 2ABCD 11234 1234030A 0 0 3
1 0 1 00000001 1 2ABCD 11234 00000000 1 0 3
0 0 F 00000000 1 2ABCD 11234 ABCD0007 1 0 3
0 1 F 00000000 1 2ABCD 11234 1234030B 1 0 3
1 1 2 00000001 1 2ABCD 11234 00000000 1 0 0
0 1 F 00000000 1 2ABCD 11234 1234000B 1 0 0
1 1 1 00000010 1 2ABCD 11234 00000000 0 0 8
0 0 F 00000000 1 2ABCD 11234 ABCD0006 0 0 8
1 1 F 00000011 1 2ABCD 11234 00000000 1 0 8
0 0 F 00000000 1 2ABCD 11234 ABCD0007 1 0 8
0 1 F 00000000 1 2ABCD 11234 1234001B 1 0 8
1 0 F 00000610 1 2ABCD 11234 00000000 0 E 8
0 0 F 00000000 0 00000 00000 00000610 0 E 8
0 1 F 00000000 0 00000 00000 00000010 0 E 8
1 0 0 FFFFFFFF 1 2ABCD 11234 00000000 0 E 8
0 0 F 00000000 1 2ABCD 11234 ABCD0616 0 E 8
2 0 0 00000000 0 00000 00000 00000000 0 0 0

// File: tb.f
gt_bus_pkg.sv
gt_lane_pkg.sv
gt_bus_decode.sv
gt_lane_ctrl.sv
gt_status_read.sv
gt_ctrl_top.sv
tb_clkgen.sv
tb_checker.sv
tb_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TEST OK

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
